// ==== design/snakeScorePkg.sv ====
package snakeScorePkg;

  // score digits shown, index 0 is the ones digit
  localparam int numDigits = 3;

  // clocks each digit holds the segment bus
  localparam int scanTicks = 4;

  // reaching this score ends the game as a win
  localparam logic [4*numDigits-1:0] winScore = 12'h025;

  // one BCD digit of the score
  typedef logic [3:0] bcdDigitT;

  // segments active high, bit 0 is segment a, bit 6 is segment g
  typedef logic [6:0] segPatternT;

  // what the head ran into
  // crash covers body, border and obstacle alike
  typedef enum logic {
    appleHit = 1'b0,
    crashHit = 1'b1
  } hitKindT;

endpackage

// ==== design/collisionJudge.sv ====
module collisionJudge import snakeScorePkg::*; (
  input  logic    hwclk,
  input  logic    rst,
  input  logic    pixelValid,
  input  logic    snakeHead,
  input  logic    snakeBody,
  input  logic    apple,
  input  logic    border,
  input  logic    obstacle,
  output logic    hitReq,
  output hitKindT hitKind,
  input  logic    hitAck
);

  logic headHit;
  logic crashFlag;
  logic hitCycle;
  logic waitRelease;
  logic idle;

  // head sits on a real pixel this cycle
  assign headHit = pixelValid && snakeHead;
  // anything that kills the snake
  assign crashFlag = snakeBody || border || obstacle;
  assign hitCycle = headHit && (apple || crashFlag);

  // no handshake in flight, not even the tail of one
  assign idle = !hitReq && !waitRelease && !hitAck;

  // request side of the four-phase handshake
  // states: idle, request up, waiting for ack to drop
  always_ff @(posedge hwclk) begin
    if (rst) begin
      hitReq <= 1'b0;
      waitRelease <= 1'b0;
    end else if (idle) begin
      // hits are only taken from idle, others are lost
      hitReq <= hitCycle;
    end else if (hitReq && hitAck) begin
      // ack seen, drop request
      hitReq <= 1'b0;
      waitRelease <= 1'b1;
    end else if (waitRelease && !hitAck) begin
      // tracker has let go of ack
      waitRelease <= 1'b0;
    end
  end

  // kind captured with the request and held until the next one
  // crash takes priority over apple on the same pixel
  always_ff @(posedge hwclk) begin
    if (idle && hitCycle) begin
      hitKind <= crashFlag ? crashHit : appleHit;
    end
  end

endmodule

// ==== design/scoreTracker.sv ====
module scoreTracker import snakeScorePkg::*; (
  input  logic                      hwclk,
  input  logic                      rst,
  input  logic                      hitReq,
  input  hitKindT                   hitKind,
  output logic                      hitAck,
  output bcdDigitT [numDigits-1:0]  digits,
  output logic                      gameOver
);

  bcdDigitT [numDigits-1:0] nextDigits;
  logic carry;
  logic accept;

  // rising edge of ack, the one cycle a hit is applied
  assign accept = hitReq && !hitAck;

  // score plus one, decimal carry rippling up the digits
  always_comb begin
    carry = 1'b1;
    for (int i = 0; i < numDigits; i++) begin
      if (!carry) begin
        nextDigits[i] = digits[i];
      end else if (digits[i] == 4'd9) begin
        // 9 rolls to 0, carry into the next digit
        nextDigits[i] = 4'd0;
        carry = 1'b1;
      end else begin
        nextDigits[i] = digits[i] + 4'd1;
        carry = 1'b0;
      end
    end
  end

  // ack simply follows req one cycle late
  // that gives raise after req and drop after req falls
  always_ff @(posedge hwclk) begin
    if (rst) begin
      hitAck <= 1'b0;
    end else begin
      hitAck <= hitReq;
    end
  end

  always_ff @(posedge hwclk) begin
    if (rst) begin
      digits <= '0;
      gameOver <= 1'b0;
    end else if (accept && !gameOver) begin
      if (hitKind == crashHit) begin
        gameOver <= 1'b1;
      end else begin
        digits <= nextDigits;
        // win check on the new score
        if (nextDigits == winScore) begin
          gameOver <= 1'b1;
        end
      end
    end
    // after game over hits are acked but ignored
  end

endmodule

// ==== design/segmentDecoder.sv ====
module segmentDecoder import snakeScorePkg::*; (
  input  bcdDigitT   digit,
  output segPatternT pattern
);

  // gfedcba order, segment a in bit 0
  always_comb begin
    case (digit)
      4'd0: pattern = 7'h3F;
      4'd1: pattern = 7'h06;
      4'd2: pattern = 7'h5B;
      4'd3: pattern = 7'h4F;
      4'd4: pattern = 7'h66;
      4'd5: pattern = 7'h6D;
      4'd6: pattern = 7'h7D;
      4'd7: pattern = 7'h07;
      4'd8: pattern = 7'h7F;
      4'd9: pattern = 7'h6F;
      // codes 10 to 15 are not BCD, show nothing
      default: pattern = 7'h00;
    endcase
  end

endmodule

// ==== design/displayScanner.sv ====
module displayScanner import snakeScorePkg::*; (
  input  logic                       hwclk,
  input  logic                       rst,
  input  segPatternT [numDigits-1:0] patterns,
  input  logic                       gameOver,
  output segPatternT                 seg,
  output logic [numDigits-1:0]       digitSel
);

  logic [$clog2(scanTicks)-1:0] tickCount;
  logic [$clog2(numDigits)-1:0] digitIdx;
  logic roundOdd;
  logic lastTick;
  logic lastDigit;
  logic blank;

  // end of this digit's slot, end of the whole round
  assign lastTick = tickCount == ($bits(tickCount))'(scanTicks - 1);
  assign lastDigit = digitIdx == ($bits(digitIdx))'(numDigits - 1);

  always_ff @(posedge hwclk) begin
    if (rst) begin
      tickCount <= '0;
      digitIdx <= '0;
      roundOdd <= 1'b0;
    end else if (lastTick) begin
      tickCount <= '0;
      if (lastDigit) begin
        // round done, wrap to digit 0 and flip parity
        digitIdx <= '0;
        roundOdd <= !roundOdd;
      end else begin
        digitIdx <= digitIdx + 1'b1;
      end
    end else begin
      tickCount <= tickCount + 1'b1;
    end
  end

  // one-hot select straight from the index
  assign digitSel = ($bits(digitSel))'(1) << digitIdx;

  // blink: odd rounds go dark once the game is over
  assign blank = gameOver && roundOdd;

  // no register on the way out, seg tracks the selected digit
  assign seg = blank ? '0 : patterns[digitIdx];

endmodule

// ==== design/snakeScoreTop.sv ====
module snakeScoreTop import snakeScorePkg::*; (
  input  logic                      hwclk,
  input  logic                      rst,
  input  logic                      pixelValid,
  input  logic                      snakeHead,
  input  logic                      snakeBody,
  input  logic                      apple,
  input  logic                      border,
  input  logic                      obstacle,
  output bcdDigitT [numDigits-1:0]  score,
  output logic                      gameOver,
  output segPatternT                seg,
  output logic [numDigits-1:0]      digitSel
);

  // hit handshake, judge to tracker
  logic hitReq;
  logic hitAck;
  hitKindT hitKind;

  // decoded digits on their way to the scanner
  segPatternT [numDigits-1:0] patterns;

  collisionJudge judge (
    .hwclk(hwclk), .rst(rst),
    .pixelValid(pixelValid), .snakeHead(snakeHead), .snakeBody(snakeBody),
    .apple(apple), .border(border), .obstacle(obstacle),
    .hitReq(hitReq), .hitKind(hitKind), .hitAck(hitAck)
  );

  scoreTracker tracker (
    .hwclk(hwclk), .rst(rst),
    .hitReq(hitReq), .hitKind(hitKind), .hitAck(hitAck),
    .digits(score), .gameOver(gameOver)
  );

  // one decoder per score digit
  for (genvar i = 0; i < numDigits; i++) begin : decoderGen
    segmentDecoder decoder (
      .digit(score[i]),
      .pattern(patterns[i])
    );
  end

  displayScanner scanner (
    .hwclk(hwclk), .rst(rst),
    .patterns(patterns), .gameOver(gameOver),
    .seg(seg), .digitSel(digitSel)
  );

endmodule

// ==== verif/snakeScore_props.sv ====
module snakeScoreProps import snakeScorePkg::*; (
  input logic    hwclk,
  input logic    rst,
  input logic    hitReq,
  input logic    hitAck,
  input hitKindT hitKind
);
  timeunit 1ns;
  timeprecision 100ps;

  // ack only ever answers a request
  ackAfterReq: assert property (@(posedge hwclk) disable iff (rst)
    $rose(hitAck) |-> $past(hitReq))
    else $error("hitAck rose with no request in the cycle before");

  // request held up until the tracker answers
  reqHeld: assert property (@(posedge hwclk) disable iff (rst)
    hitReq && !hitAck |=> hitReq)
    else $error("hitReq dropped before hitAck arrived");

  // kind is latched with the request and must not move
  kindHeld: assert property (@(posedge hwclk) disable iff (rst)
    hitReq && $past(hitReq) |-> $stable(hitKind))
    else $error("hitKind changed while hitReq was high");

endmodule

// watch the handshake where the tracker sees it
bind scoreTracker snakeScoreProps handshakeProps (
  .hwclk(hwclk), .rst(rst),
  .hitReq(hitReq), .hitAck(hitAck), .hitKind(hitKind)
);

// ==== verif/snakeScoreTb.sv ====
module snakeScoreTb import snakeScorePkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  logic hwclk = 1'b0;
  logic rst;
  logic pixelValid, snakeHead, snakeBody, apple, border, obstacle;
  bcdDigitT [numDigits-1:0] score;
  logic gameOver;
  segPatternT seg;
  logic [numDigits-1:0] digitSel;

  // reference model counting in plain decimal
  int modelCount;
  logic modelOver;
  int busyLeft;
  // model state one and two clocks back
  // the DUT shows the older one
  int h1Count, h2Count;
  logic h1Over, h2Over;
  // clocks since reset was released
  int tick;
  string caseName;
  int valueErrors, fileErrors, timeoutErrors;

  always #2 hwclk = ~hwclk;

  snakeScoreTop i_dut (
    .hwclk, .rst, .pixelValid, .snakeHead, .snakeBody, .apple, .border, .obstacle,
    .score, .gameOver, .seg, .digitSel
  );

  function automatic logic [4*numDigits-1:0] toBcd(input int count);
    logic [4*numDigits-1:0] bcd;
    int rest;
    rest = count;
    for (int i = 0; i < numDigits; i++) begin
      bcd[4*i +: 4] = 4'(rest % 10);
      rest = rest / 10;
    end
    return bcd;
  endfunction

  // lit segments of the usual digit shapes in gfedcba order
  function automatic segPatternT standardPattern(input logic [3:0] d);
    case (d)
      4'd0: return 7'b0111111;
      4'd1: return 7'b0000110;
      4'd2: return 7'b1011011;
      4'd3: return 7'b1001111;
      4'd4: return 7'b1100110;
      4'd5: return 7'b1101101;
      4'd6: return 7'b1111101;
      4'd7: return 7'b0000111;
      4'd8: return 7'b1111111;
      4'd9: return 7'b1101111;
      default: return 7'b0000000;
    endcase
  endfunction

  task automatic checkOutputs();
    int shownDigit;
    logic roundOdd;
    logic [4*numDigits-1:0] expDigits;
    logic [numDigits-1:0] expSel;
    segPatternT expSeg;
    shownDigit = (tick / scanTicks) % numDigits;
    roundOdd = ((tick / (scanTicks * numDigits)) % 2) == 1;
    expDigits = toBcd(h2Count);
    expSel = '0;
    expSel[shownDigit] = 1'b1;
    // odd rounds go dark once the game is over
    expSeg = (h2Over && roundOdd) ? '0 : standardPattern(expDigits[4*shownDigit +: 4]);
    assert (score == expDigits) else begin
      $display("** Error %s: score expected %h actual %h", caseName, expDigits, score);
      valueErrors++;
    end
    assert (gameOver == h2Over) else begin
      $display("** Error %s: gameOver expected %b actual %b", caseName, h2Over, gameOver);
      valueErrors++;
    end
    assert (digitSel == expSel) else begin
      $display("** Error %s: digitSel expected %b actual %b", caseName, expSel, digitSel);
      valueErrors++;
    end
    assert (seg == expSeg) else begin
      $display("** Error %s: seg expected %h actual %h", caseName, expSeg, seg);
      valueErrors++;
    end
  endtask

  // one clock with the inputs already driven
  // model steps first and the outputs are compared after the edge
  task automatic clockCycle();
    logic hit;
    logic crash;
    crash = snakeBody || border || obstacle;
    hit = pixelValid && snakeHead && (apple || crash);
    if (busyLeft > 0) begin
      // handshake still running so the hit is lost
      busyLeft--;
    end else if (hit) begin
      busyLeft = 4;
      if (!modelOver) begin
        if (crash) begin
          modelOver = 1'b1;
        end else begin
          modelCount++;
          if (toBcd(modelCount) == winScore) begin
            modelOver = 1'b1;
          end
        end
      end
    end
    @(posedge hwclk);
    #1;
    tick++;
    h2Count = h1Count;
    h2Over = h1Over;
    h1Count = modelCount;
    h1Over = modelOver;
    checkOutputs();
  endtask

  task automatic clearFlags();
    pixelValid = 1'b0;
    snakeHead = 1'b0;
    snakeBody = 1'b0;
    apple = 1'b0;
    border = 1'b0;
    obstacle = 1'b0;
  endtask

  task automatic applyReset();
    rst = 1'b1;
    clearFlags();
    repeat (16) @(posedge hwclk);
    #1;
    rst = 1'b0;
    modelCount = 0;
    modelOver = 1'b0;
    busyLeft = 0;
    h1Count = 0;
    h2Count = 0;
    h1Over = 1'b0;
    h2Over = 1'b0;
    tick = 0;
    checkOutputs();
    assert ($onehot(digitSel)) else begin
      $display("** Error %s: digitSel expected one-hot actual %b", caseName, digitSel);
      valueErrors++;
    end
  endtask

  task automatic waitHandshakeIdle(input int limit);
    int waited;
    waited = 0;
    while ((i_dut.hitReq || i_dut.hitAck) && waited < limit) begin
      clockCycle();
      waited++;
    end
    if (i_dut.hitReq || i_dut.hitAck) begin
      $display("hit handshake still busy after %0d cycles", limit);
      timeoutErrors++;
    end
  endtask

  task automatic waitForDigit(input int idx, input int limit);
    int waited;
    waited = 0;
    while (!digitSel[idx] && waited < limit) begin
      clockCycle();
      waited++;
    end
    if (!digitSel[idx]) begin
      $display("digit %0d was never selected within %0d cycles", idx, limit);
      timeoutErrors++;
    end
  endtask

  initial begin
    string line;
    int fd, n, rstFlag, v, h, b, a, bo, o, gap, expScore, expOver;
    int blanks[2];
    valueErrors = 0;
    fileErrors = 0;
    timeoutErrors = 0;
    caseName = "reset";
    applyReset();
    fd = $fopen("verif/snakeScoreCases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file");
      fileErrors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // skip blank lines and the column notes
        if (n > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
          n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d", caseName, rstFlag,
                      v, h, b, a, bo, o, gap, expScore, expOver);
          if (n != 11) begin
            $display("malformed case line: %s", line);
            fileErrors++;
          end else begin
            if (rstFlag != 0) begin
              applyReset();
            end
            pixelValid = v[0];
            snakeHead = h[0];
            snakeBody = b[0];
            apple = a[0];
            border = bo[0];
            obstacle = o[0];
            clockCycle();
            // model already holds this line's outcome
            assert (modelCount == expScore && modelOver == expOver[0]) else begin
              $display("** Error %s: score/gameOver expected %0d/%0d actual %0d/%0b in the model",
                       caseName, expScore, expOver, modelCount, modelOver);
              fileErrors++;
            end
            clearFlags();
            repeat (gap) clockCycle();
          end
        end
      end
      $fclose(fd);
    end

    // blinking over two whole rounds from the start of a round
    waitHandshakeIdle(20);
    caseName = "display";
    waitForDigit(numDigits - 1, 4 * scanTicks * numDigits);
    waitForDigit(0, 4 * scanTicks * numDigits);
    for (int r = 0; r < 2; r++) begin
      blanks[r] = 0;
      repeat (scanTicks * numDigits) begin
        if (seg == '0) begin
          blanks[r]++;
        end
        clockCycle();
      end
    end
    assert (gameOver && ((blanks[0] == 0 && blanks[1] == scanTicks * numDigits) ||
                         (blanks[1] == 0 && blanks[0] == scanTicks * numDigits))) else begin
      $display("display did not alternate shown and blank rounds after game over");
      valueErrors++;
    end

    $display("checks done: %0d value errors, %0d file errors, %0d timeouts",
             valueErrors, fileErrors, timeoutErrors);
    if (valueErrors + fileErrors + timeoutErrors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
design/snakeScorePkg.sv
design/collisionJudge.sv
design/scoreTracker.sv
design/segmentDecoder.sv
design/displayScanner.sv
design/snakeScoreTop.sv
verif/snakeScore_props.sv
verif/snakeScoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module snakeScoreTb -o snakeScoreSim \
  && ./obj_dir/snakeScoreSim | tee /dev/stderr | grep -qF "Test completed successfully" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== verif/snakeScoreCases.txt ====
# name reset valid head body apple border obstacle gap score gameOver
# reset=1 restarts the game before the hit, score in decimal, gap in idle cycles
apple01 0 1 1 0 1 0 0 4 1 0
apple02 0 1 1 0 1 0 0 4 2 0
apple03 0 1 1 0 1 0 0 4 3 0
apple04 0 1 1 0 1 0 0 4 4 0
apple05 0 1 1 0 1 0 0 4 5 0
apple06 0 1 1 0 1 0 0 4 6 0
apple07 0 1 1 0 1 0 0 4 7 0
apple08 0 1 1 0 1 0 0 4 8 0
apple09 0 1 1 0 1 0 0 4 9 0
carry10 0 1 1 0 1 0 0 4 10 0
dropA1 0 1 1 0 1 0 0 0 11 0
dropA2 0 1 1 0 1 0 0 4 11 0
dropB1 0 1 1 0 1 0 0 3 12 0
dropB2 0 1 1 0 1 0 0 4 12 0
noValid 0 0 1 0 1 0 0 4 12 0
noHead 0 1 0 0 1 0 0 4 12 0
apple13 0 1 1 0 1 0 0 4 13 0
apple14 0 1 1 0 1 0 0 4 14 0
apple15 0 1 1 0 1 0 0 4 15 0
apple16 0 1 1 0 1 0 0 4 16 0
apple17 0 1 1 0 1 0 0 4 17 0
apple18 0 1 1 0 1 0 0 4 18 0
apple19 0 1 1 0 1 0 0 4 19 0
carry20 0 1 1 0 1 0 0 4 20 0
apple21 0 1 1 0 1 0 0 4 21 0
apple22 0 1 1 0 1 0 0 4 22 0
apple23 0 1 1 0 1 0 0 4 23 0
apple24 0 1 1 0 1 0 0 4 24 0
win25 0 1 1 0 1 0 0 4 25 1
afterWin 0 1 1 0 1 0 0 6 25 1
crashBody 1 1 1 1 0 0 0 4 0 1
afterCrash 0 1 1 0 1 0 0 6 0 1
bothBorder 1 1 1 0 1 1 0 6 0 1
crashObstacle 1 1 1 0 0 0 1 8 0 1
